/* verilog/smc_pkg.sv */
//--------------------------------------------------------------------------
// Shared types and helpers for the lite static memory controller
// Little-endian only, two banks, bank picked by address bit 28
// Requester data is right-justified, a byte in [7:0], a halfword in [15:0]
//--------------------------------------------------------------------------
`default_nettype none

package smc_pkg;

   typedef logic [31:0] smc_addr_t;   // Byte address
   typedef logic [31:0] smc_data_t;   // Data word
   typedef logic [3:0]  smc_be_t;     // Byte enables, active low
   typedef logic [1:0]  smc_size_t;   // Transfer or bus size code
   typedef logic [1:0]  smc_num_t;    // Accesses still to do

   // Size codes, shared by transfer and bus
   localparam smc_size_t size_8  = 2'b00;
   localparam smc_size_t size_16 = 2'b01;
   localparam smc_size_t size_32 = 2'b10;

   localparam int bank_sel_bit = 28;  // Set for bank 1

   typedef enum logic [1:0]
   {
      st_idle = 2'b00,
      st_rw   = 2'b01,                // Memory access in progress
      st_gap  = 2'b10                 // Turnaround between accesses
   } smc_state_t;

   typedef struct packed
   {
      smc_addr_t  addr;
      smc_size_t  xfer_size;
      logic       write;              // High for a write
      smc_data_t  wdata;
   } smc_req_t;

   typedef struct packed
   {
      smc_addr_t  addr;
      logic [1:0] n_cs;               // Bit 0 drives bank 0
      smc_be_t    n_be;
      logic       n_we;
      smc_data_t  wdata;
   } smc_ext_t;

   // Bus width in bits to size code
   function automatic smc_size_t bits_to_size(input int bits);
      case (bits)
         8:       return size_8;
         16:      return size_16;
         default: return size_32;
      endcase
   endfunction

   // Data bits covered by a size code
   function automatic smc_data_t size_mask(input smc_size_t size);
      case (size)
         size_8:  return 32'h0000_00FF;
         size_16: return 32'h0000_FFFF;
         default: return 32'hFFFF_FFFF;
      endcase
   endfunction

endpackage

`default_nettype wire

/* verilog/smc_arbiter.sv */
//--------------------------------------------------------------------------
// Round-robin arbiter for two requesters
// A requester must hold req and its info until its done pulse
// Start strobe is combinational and only fires while the FSM is idle
//--------------------------------------------------------------------------
`default_nettype none

module smc_arbiter import smc_pkg::*;
(
   input  wire logic       sys_clk3,
   input  wire logic       n_sys_reset3,
   input  wire logic [1:0] req,           // Request levels
   input  wire smc_req_t   req_info0,
   input  wire smc_req_t   req_info1,
   input  wire logic       idle,          // FSM in st_idle
   output logic            valid_access,  // One-cycle start strobe
   output logic            grant_id,      // Owner of the bus
   output smc_req_t        sel_req        // Request of the owner
);

   logic r_grant;    // Last granted requester
   logic pick;       // Winner of this cycle

   // Any request starts a transfer once the FSM is free
   assign valid_access = idle & (|req);

   // Last winner yields on a tie
   always_comb
   begin
      if (&req)
         pick = ~r_grant;
      else
         pick = req[1];
   end

   //------------------------------------------------------------------------
   // Grant register, held for the whole transfer
   //------------------------------------------------------------------------
   always_ff @(posedge sys_clk3 or negedge n_sys_reset3)
   begin
      if (!n_sys_reset3)
         r_grant <= 1'b1;        // First tie goes to requester 0
      else if (valid_access)
         r_grant <= pick;
   end

   assign grant_id = valid_access ? pick : r_grant;   // New owner in cycle 0

   // Info of the owner, stable while its req is held
   assign sel_req = grant_id ? req_info1 : req_info0;

   // A start takes the FSM out of idle on the next cycle
   a_start_leaves_idle : assert property (
      @(posedge sys_clk3) disable iff (!n_sys_reset3)
      valid_access |-> idle ##1 !idle);

endmodule

`default_nettype wire

/* verilog/smc_state_ctrl.sv */
//--------------------------------------------------------------------------
// Access FSM with wait-state and access counters
// Every access spends WAIT_STATES+1 cycles in st_rw, then one st_gap
// Done comes in the last st_rw cycle of the final access
//--------------------------------------------------------------------------
`default_nettype none

module smc_state_ctrl import smc_pkg::*;
#(
   parameter int WAIT_STATES = 1          // Extra cycles per access
)
(
   input  wire logic      sys_clk3,
   input  wire logic      n_sys_reset3,
   input  wire logic      valid_access,  // Start strobe
   input  wire smc_size_t v_xfer_size,   // Transfer size, valid in cycle 0
   input  wire smc_size_t v_bus_size,    // Bus size, valid in cycle 0
   output smc_state_t     nextstate,
   output smc_num_t       num_access,    // Accesses left after this one
   output logic           last_cycle,    // Final st_rw cycle of an access
   output logic           smc_done,      // Transfer complete
   output logic           idle
);

   // Wait counter width, at least one bit
   localparam int ww = (WAIT_STATES > 0) ? $clog2(WAIT_STATES + 1) : 1;

   smc_state_t    r_state;
   logic [ww-1:0] r_wait;     // Cycles spent in this access
   smc_num_t      r_num;      // Stored access count
   smc_num_t      load_num;   // Count for a new transfer

   //------------------------------------------------------------------------
   // Accesses beyond the first, from the size ratio
   //------------------------------------------------------------------------
   always_comb
   begin
      if (v_xfer_size <= v_bus_size)
         load_num = 2'd0;                      // Fits in one access
      else if ((v_xfer_size - v_bus_size) == 2'd2)
         load_num = 2'd3;                      // Word on byte bus
      else
         load_num = 2'd1;
   end

   assign idle       = (r_state == st_idle);
   assign last_cycle = (r_state == st_rw) && (r_wait == ww'(WAIT_STATES));
   assign smc_done   = last_cycle && (r_num == 2'd0);

   // Next state
   always_comb
   begin
      case (r_state)
         st_idle: nextstate = valid_access ? st_rw : st_idle;
         st_rw:
         begin
            if (!last_cycle)
               nextstate = st_rw;              // Still waiting
            else if (r_num == 2'd0)
               nextstate = st_idle;
            else
               nextstate = st_gap;
         end
         st_gap:  nextstate = st_rw;           // Gap is always one cycle
         default: nextstate = st_idle;
      endcase
   end

   // Count for the access being set up, so the gap shows the next one
   always_comb
   begin
      if (valid_access)
         num_access = load_num;
      else if (r_state == st_gap)
         num_access = r_num - 2'd1;
      else
         num_access = r_num;
   end

   //------------------------------------------------------------------------
   // State and counters
   //------------------------------------------------------------------------
   always_ff @(posedge sys_clk3 or negedge n_sys_reset3)
   begin
      if (!n_sys_reset3)
      begin
         r_state <= st_idle;
         r_wait  <= '0;
         r_num   <= 2'd0;
      end
      else
      begin
         r_state <= nextstate;
         if ((nextstate == st_rw) && (r_state != st_rw))
            r_wait <= '0;                      // Fresh access
         else if ((r_state == st_rw) && !last_cycle)
            r_wait <= r_wait + 1'b1;
         if (valid_access)
            r_num <= load_num;
         else if (r_state == st_gap)
            r_num <= num_access;               // One access finished
      end
   end

   // Count only falls inside a transfer, a wrap past zero would raise it
   a_num_no_underflow : assert property (
      @(posedge sys_clk3) disable iff (!n_sys_reset3)
      (r_state == st_rw) && !$past(valid_access) |-> (r_num <= $past(r_num)));

endmodule

`default_nettype wire

/* verilog/smc_addr.sv */
//--------------------------------------------------------------------------
// Address, chip select and byte enables for each external access
// Bank widths are fixed by parameter, bank 1 when address bit 28 is set
// Split transfers walk the low address bits from the top byte down
//--------------------------------------------------------------------------
`default_nettype none

module smc_addr import smc_pkg::*;
#(
   parameter int BANK0_BUS = 32,          // Bank 0 width in bits
   parameter int BANK1_BUS = 8            // Bank 1 width in bits
)
(
   input  wire logic       sys_clk3,
   input  wire logic       n_sys_reset3,
   input  wire logic       valid_access,
   input  wire smc_req_t   sel_req,
   input  wire smc_state_t nextstate,
   input  wire smc_num_t   num_access,   // Accesses left after this one
   input  wire logic       smc_done,
   output smc_size_t       v_bus_size,
   output smc_size_t       v_xfer_size,
   output smc_addr_t       ext_addr,
   output logic [1:0]      ext_n_cs,
   output smc_be_t         ext_n_be,
   output smc_be_t         n_be           // Unregistered lane enables
);

   localparam smc_size_t bus0_size = bits_to_size(BANK0_BUS);
   localparam smc_size_t bus1_size = bits_to_size(BANK1_BUS);

   logic       r_active;     // Transfer in flight
   logic       r_cs;         // Stored bank
   smc_addr_t  r_addr;       // Stored request address
   smc_size_t  r_xfer_size;
   logic       v_cs;         // Bank for this cycle
   smc_addr_t  v_addr;
   logic [1:0] lo_addr;      // Low address bits of this access

   //------------------------------------------------------------------------
   // Request store
   //------------------------------------------------------------------------
   always_ff @(posedge sys_clk3 or negedge n_sys_reset3)
   begin
      if (!n_sys_reset3)
      begin
         r_active <= 1'b0;
         r_cs     <= 1'b0;
      end
      else if (valid_access)
      begin
         r_active <= 1'b1;
         r_cs     <= sel_req.addr[bank_sel_bit];
      end
      else if (smc_done)
         r_active <= 1'b0;
   end

   always_ff @(posedge sys_clk3)
   begin
      if (valid_access)
      begin
         r_addr      <= sel_req.addr;
         r_xfer_size <= sel_req.xfer_size;
      end
   end

   // Live values in cycle 0, stored ones afterwards
   assign v_cs        = valid_access ? sel_req.addr[bank_sel_bit] : r_cs;
   assign v_addr      = valid_access ? sel_req.addr : r_addr;
   assign v_xfer_size = valid_access ? sel_req.xfer_size : r_xfer_size;
   assign v_bus_size  = v_cs ? bus1_size : bus0_size;

   // Low address bits, most significant part of the word first
   always_comb
   begin
      case ({v_xfer_size, v_bus_size})
         {size_32, size_32}: lo_addr = 2'b00;
         {size_32, size_16}: lo_addr = {num_access[0], 1'b0};   // 10 then 00
         {size_32, size_8}:  lo_addr = num_access;              // 11 down to 00
         {size_16, size_8}:  lo_addr = {v_addr[1], num_access[0]};
         {size_16, size_16},
         {size_16, size_32}: lo_addr = {v_addr[1], 1'b0};
         default:            lo_addr = v_addr[1:0];             // Bytes
      endcase
   end

   //------------------------------------------------------------------------
   // Lane enables, little endian
   //------------------------------------------------------------------------
   always_comb
   begin
      n_be = 4'b1111;
      if (valid_access || r_active)
      begin
         case ({v_xfer_size, v_bus_size})
            {size_8, size_8},
            {size_16, size_8},
            {size_32, size_8}:  n_be = 4'b1110;               // Lane 0 only
            {size_8, size_16}:  n_be = v_addr[0] ? 4'b1101 : 4'b1110;
            {size_16, size_16},
            {size_32, size_16}: n_be = 4'b1100;
            {size_8, size_32}:  n_be = ~(4'b0001 << v_addr[1:0]);
            {size_16, size_32}: n_be = v_addr[1] ? 4'b0011 : 4'b1100;
            {size_32, size_32}: n_be = 4'b0000;
            default:            n_be = 4'b1111;               // Bad size code
         endcase
      end
   end

   // External outputs, live only for st_rw
   always_ff @(posedge sys_clk3 or negedge n_sys_reset3)
   begin
      if (!n_sys_reset3)
      begin
         ext_addr <= '0;
         ext_n_cs <= 2'b11;
         ext_n_be <= 4'hF;
      end
      else if (nextstate == st_rw)
      begin
         ext_addr <= {v_addr[31:2], lo_addr};
         ext_n_cs <= v_cs ? 2'b01 : 2'b10;
         ext_n_be <= n_be;
      end
      else
      begin
         ext_n_cs <= 2'b11;    // Gap or idle, address kept
         ext_n_be <= 4'hF;
      end
   end

   // A selected bank always sees at least one lane
   a_be_with_cs : assert property (
      @(posedge sys_clk3) disable iff (!n_sys_reset3)
      (ext_n_cs != 2'b11) |-> (ext_n_be != 4'hF));

endmodule

`default_nettype wire

/* verilog/smc_data_path.sv */
//--------------------------------------------------------------------------
// Write lane steering and read assembly over split transfers
// Read data out is only meaningful in the done cycle
//--------------------------------------------------------------------------
`default_nettype none

module smc_data_path import smc_pkg::*;
(
   input  wire logic       sys_clk3,
   input  wire logic       n_sys_reset3,
   input  wire logic       valid_access,
   input  wire smc_req_t   sel_req,
   input  wire smc_size_t  v_bus_size,
   input  wire smc_state_t nextstate,
   input  wire smc_num_t   num_access,
   input  wire logic       last_cycle,   // Read sample point
   input  wire smc_be_t    n_be,
   input  wire smc_data_t  ext_rdata,
   output smc_data_t       ext_wdata,
   output logic            ext_n_we,
   output smc_data_t       rdata
);

   smc_data_t  part_mask;    // Bits carried by one access
   logic [5:0] part_shift;   // Position of this access in the word
   logic [4:0] lane_shift;   // Lowest enabled lane, in bits
   smc_data_t  r_collect;    // Read bytes gathered so far
   smc_data_t  rd_merge;

   assign part_mask  = size_mask(v_bus_size) & size_mask(sel_req.xfer_size);
   assign part_shift = {4'b0000, num_access} << (3 + v_bus_size);

   always_comb
   begin
      casez (n_be)
         4'b???0: lane_shift = 5'd0;
         4'b??01: lane_shift = 5'd8;
         4'b?011: lane_shift = 5'd16;
         4'b0111: lane_shift = 5'd24;
         default: lane_shift = 5'd0;     // No lane enabled
      endcase
   end

   //------------------------------------------------------------------------
   // Write side
   //------------------------------------------------------------------------
   always_ff @(posedge sys_clk3 or negedge n_sys_reset3)
   begin
      if (!n_sys_reset3)
         ext_n_we <= 1'b1;
      else
         ext_n_we <= !((nextstate == st_rw) && sel_req.write);
   end

   // Slice for this access, moved onto its lanes
   always_ff @(posedge sys_clk3)
   begin
      if (nextstate == st_rw)
         ext_wdata <= ((sel_req.wdata >> part_shift) & part_mask) << lane_shift;
   end

   // Read side, current lanes dropped into their slot
   assign rd_merge = (r_collect & ~(part_mask << part_shift))
                   | (((ext_rdata >> lane_shift) & part_mask) << part_shift);
   assign rdata    = rd_merge;

   always_ff @(posedge sys_clk3)
   begin
      if (valid_access)
         r_collect <= '0;                // Upper bytes read as zero
      else if (last_cycle && !sel_req.write)
         r_collect <= rd_merge;
   end

endmodule

`default_nettype wire

/* verilog/smc_top.sv */
//--------------------------------------------------------------------------
// Lite static memory controller, two requesters onto two memory banks
// Bank widths of 8, 16 or 32 bits, fixed wait states, no bursts
//--------------------------------------------------------------------------
`default_nettype none

module smc_top import smc_pkg::*;
#(
   parameter int WAIT_STATES = 1,
   parameter int BANK0_BUS   = 32,
   parameter int BANK1_BUS   = 8
)
(
   input  wire logic       sys_clk3,
   input  wire logic       n_sys_reset3,
   input  wire logic [1:0] req,          // Held until done
   input  wire smc_req_t   req_info0,
   input  wire smc_req_t   req_info1,
   output logic [1:0]      done,         // One pulse per transfer
   output smc_data_t       rdata,        // Valid with done
   output smc_ext_t        ext,          // External memory bus
   input  wire smc_data_t  ext_rdata
);

   logic       valid_access;
   logic       grant_id;
   logic       idle;
   logic       last_cycle;
   logic       smc_done;
   smc_req_t   sel_req;
   smc_state_t nextstate;
   smc_num_t   num_access;
   smc_size_t  v_bus_size;
   smc_size_t  v_xfer_size;
   smc_be_t    n_be;
   smc_addr_t  ext_addr;
   logic [1:0] ext_n_cs;
   smc_be_t    ext_n_be;
   logic       ext_n_we;
   smc_data_t  ext_wdata;

   smc_arbiter arb_i (.*);

   smc_state_ctrl #(.WAIT_STATES(WAIT_STATES)) ctrl_i (.*);

   smc_addr #(.BANK0_BUS(BANK0_BUS), .BANK1_BUS(BANK1_BUS)) addr_i (.*);

   smc_data_path data_i (.*);

   // Done to the owner of the transfer
   assign done = smc_done ? (grant_id ? 2'b10 : 2'b01) : 2'b00;

   assign ext = '{addr: ext_addr, n_cs: ext_n_cs, n_be: ext_n_be,
                  n_we: ext_n_we, wdata: ext_wdata};

endmodule

`default_nettype wire

/* verif/smc_ext_mem.sv */
//--------------------------------------------------------------------------
// Behavioral two-bank byte memory on the external SMC bus
// Only address bits [9:0] decode, so each bank holds 1 KB
// Answers reads at once, writes and logs accesses on the falling edge
//--------------------------------------------------------------------------
`default_nettype none

module smc_ext_mem import smc_pkg::*;
#(
   parameter int BANK0_BUS = 32,          // Bank 0 width in bits
   parameter int BANK1_BUS = 8
)
(
   input  wire logic     sys_clk3,
   input  wire smc_ext_t ext,
   output smc_data_t     ext_rdata,
   output int            acc_cnt          // Accesses seen so far
);
   timeunit 1ns;
   timeprecision 100ps;

   logic [7:0] mem [0:2047];              // {bank, addr[9:0]}
   logic [5:0] acc_log [0:255];           // {addr[1:0], n_be} per access
   logic [1:0] prev_cs;
   logic       bank;                      // High for bank 1
   int         nb;                        // Lanes of the selected bank
   smc_addr_t  base;

   // Fill value, every address bit takes part
   function automatic logic [7:0] fill_byte(input int i);
      return 8'((i * 37) ^ (i >> 3));
   endfunction

   assign bank = !ext.n_cs[1];
   assign nb   = (bank ? BANK1_BUS : BANK0_BUS) / 8;
   assign base = ext.addr & ~smc_addr_t'(nb - 1);   // Bus-aligned

   initial
   begin
      for (int i = 0; i < 2048; i++)
         mem[i] = fill_byte(i);
      acc_cnt = 0;
      prev_cs = 2'b11;
   end

   always_comb
   begin
      ext_rdata = '0;
      if (ext.n_cs != 2'b11)
         for (int l = 0; l < 4; l++)
            if (l < nb)
               ext_rdata[8*l +: 8] = mem[{bank, base[9:0] + 10'(l)}];
   end

   //------------------------------------------------------------------------
   // Write and access log
   //------------------------------------------------------------------------
   always @(negedge sys_clk3)
   begin
      if ((ext.n_cs != 2'b11) && (prev_cs == 2'b11))
      begin
         acc_log[acc_cnt % 256] = {ext.addr[1:0], ext.n_be};   // New access
         acc_cnt = acc_cnt + 1;
      end
      if ((ext.n_cs != 2'b11) && !ext.n_we)
         for (int l = 0; l < 4; l++)
            if ((l < nb) && !ext.n_be[l])
               mem[{bank, base[9:0] + 10'(l)}] = ext.wdata[8*l +: 8];
      prev_cs = ext.n_cs;
   end

endmodule

`default_nettype wire

/* verif/smc_tb.sv */
//--------------------------------------------------------------------------
// Testbench for the lite SMC, bank 0 is 32 bits and bank 1 is 8 bits
// Expected lane and address checks cover 32-bit and 8-bit banks only
// Outputs are sampled on the falling edge, inputs move 1 ns after rise
//--------------------------------------------------------------------------
`default_nettype none

module smc_tb import smc_pkg::*;
();
   timeunit 1ns;
   timeprecision 100ps;

   localparam int WAIT_STATES = 1;
   localparam int BANK0_BUS   = 32;
   localparam int BANK1_BUS   = 8;
   localparam int TIMEOUT     = 200;      // Cycles per wait
   localparam int LOG_DEPTH   = 256;

   logic       sys_clk3;
   logic       n_sys_reset3;
   logic [1:0] req;
   smc_req_t   req_info [2];
   logic [1:0] done;
   smc_data_t  rdata;
   smc_ext_t   ext;
   smc_data_t  ext_rdata;
   int         acc_cnt;

   logic [31:0] lfsr;
   logic [7:0]  shadow [0:2047];          // Expected memory contents
   int          cyc;                      // Cycle number
   int          start_cyc [2];
   int          done_cnt [2];
   int          want_next;                // Owner due next, -1 for any
   bit          chk_lat;
   int          checks, errors, tests, test_err0;

   smc_top #(.WAIT_STATES(WAIT_STATES), .BANK0_BUS(BANK0_BUS), .BANK1_BUS(BANK1_BUS))
   dut_i (.sys_clk3(sys_clk3), .n_sys_reset3(n_sys_reset3), .req(req),
          .req_info0(req_info[0]), .req_info1(req_info[1]), .done(done),
          .rdata(rdata), .ext(ext), .ext_rdata(ext_rdata));

   smc_ext_mem #(.BANK0_BUS(BANK0_BUS), .BANK1_BUS(BANK1_BUS))
   mem_i (.sys_clk3(sys_clk3), .ext(ext), .ext_rdata(ext_rdata), .acc_cnt(acc_cnt));

   always #50 sys_clk3 = ~sys_clk3;
   always @(posedge sys_clk3) cyc <= cyc + 1;

   //------------------------------------------------------------------------
   // Reference model
   //------------------------------------------------------------------------
   function automatic logic [7:0] fill_byte(input int i);
      return 8'((i * 37) ^ (i >> 3));      // Same fill as the memory
   endfunction

   function automatic logic [31:0] lfsr_step(input logic [31:0] s);
      return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
   endfunction

   function automatic logic [10:0] shadow_idx(input smc_addr_t a);
      return {a[bank_sel_bit], a[9:0]};
   endfunction

   // Little endian, naturally aligned, right-justified
   function automatic smc_data_t ref_read(input smc_req_t info);
      int        nb;
      smc_addr_t base;
      smc_data_t r;
      nb   = 1 << info.xfer_size;
      base = info.addr & ~smc_addr_t'(nb - 1);
      r    = '0;
      for (int i = 0; i < nb; i++)
         r[8*i +: 8] = shadow[shadow_idx(base + i)];
      return r;
   endfunction

   // Cycles from start strobe to done
   function automatic int exp_latency(input smc_req_t info);
      int nb, bb, nacc;
      nb   = 1 << info.xfer_size;
      bb   = (info.addr[bank_sel_bit] ? BANK1_BUS : BANK0_BUS) / 8;
      nacc = (nb > bb) ? nb / bb : 1;
      return nacc * (WAIT_STATES + 2) - 1;
   endfunction

   task automatic write_shadow(input smc_req_t info);
      int        nb;
      smc_addr_t base;
      nb   = 1 << info.xfer_size;
      base = info.addr & ~smc_addr_t'(nb - 1);
      for (int i = 0; i < nb; i++)
         shadow[shadow_idx(base + i)] = info.wdata[8*i +: 8];
   endtask

   task automatic get_bits(input int n, output logic [31:0] v);
      v = '0;
      for (int i = 0; i < n; i++)
      begin
         lfsr = lfsr_step(lfsr);          // One step per bit
         v    = {v[30:0], lfsr[0]};
      end
   endtask

   task automatic check_val(input string name, input logic [31:0] got,
                            input logic [31:0] exp);
      checks++;
      assert (got === exp)
      else
      begin
         $display("Fail at %0d ns: %s is %h, expected %h", $time, name, got, exp);
         errors++;
      end
   endtask

   task automatic abort_timeout(input int k);
      $display("Timeout: requester %0d saw no done within %0d cycles", k, TIMEOUT);
      $display("Regression failed");
      $finish;
   endtask

   //------------------------------------------------------------------------
   // Stimulus, called 1 ns after a rising edge and returns there
   //------------------------------------------------------------------------
   task automatic run(input int k, input smc_req_t info);
      int n, t;
      n            = done_cnt[k];
      req_info[k]  = info;
      req[k]       = 1'b1;
      start_cyc[k] = cyc;
      t            = 0;
      while ((done_cnt[k] == n) && (t < TIMEOUT))
      begin
         @(posedge sys_clk3);
         t++;
      end
      if (done_cnt[k] == n)
         abort_timeout(k);
      else
         #1;
   endtask

   // Addresses and lanes of each external access
   task automatic check_accesses(input int first, input smc_req_t info);
      int         nb, bb, nacc;
      logic [5:0] entry;
      logic [1:0] lo;
      smc_be_t    be;
      nb   = 1 << info.xfer_size;
      bb   = (info.addr[bank_sel_bit] ? BANK1_BUS : BANK0_BUS) / 8;
      nacc = (nb > bb) ? nb / bb : 1;
      check_val("access count", acc_cnt - first, nacc);
      for (int j = 0; j < nacc; j++)
      begin
         entry = mem_i.acc_log[(first + j) % LOG_DEPTH];
         lo    = info.addr[1:0] & 2'(~(nb - 1));
         if (bb == 1)
         begin
            lo = lo + 2'(nacc - 1 - j);   // Top byte first
            be = 4'b1110;
         end
         else
            be = ~(4'((1 << nb) - 1) << lo);
         check_val("ext addr[1:0]", entry[5:4], lo);
         check_val("ext n_be", entry[3:0], be);
      end
   endtask

   task automatic xfer(input int k, input smc_addr_t addr, input smc_size_t size,
                       input logic write, input smc_data_t wdata);
      smc_req_t info;
      int       first;
      info  = '{addr: addr, xfer_size: size, write: write, wdata: wdata};
      first = acc_cnt;
      run(k, info);
      req[k] = 1'b0;
      check_accesses(first, info);
   endtask

   task automatic random_driver(input int k, input int count);
      smc_req_t    info;
      logic [31:0] v;
      for (int i = 0; i < count; i++)
      begin
         info = '0;
         get_bits(1, v);
         info.addr[bank_sel_bit] = v[0];
         get_bits(10, v);
         info.addr[9:0] = v[9:0];
         get_bits(2, v);
         info.xfer_size = (v[1:0] == 2'b11) ? size_32 : v[1:0];
         get_bits(1, v);
         info.write = v[0];
         get_bits(32, v);
         info.wdata = v;
         run(k, info);
         get_bits(1, v);
         if (v[0] || (i == count - 1))
         begin
            req[k] = 1'b0;                // Short pause, else back to back
            @(posedge sys_clk3);
            #1;
         end
      end
   endtask

   task automatic end_test(input string name);
      tests++;
      $display("Test %0d, %s: %s", tests, name,
               (errors == test_err0) ? "ok" : "mismatches seen");
      test_err0 = errors;
   endtask

   //------------------------------------------------------------------------
   // Compare process
   //------------------------------------------------------------------------
   always @(negedge sys_clk3)
   begin
      smc_req_t info;
      if (n_sys_reset3)
      begin
         assert (done != 2'b11)
         else
         begin
            $display("Error at %0d ns: done pulsed for both requesters", $time);
            errors++;
         end
         for (int k = 0; k < 2; k++)
            if (done[k])
            begin
               info = req_info[k];
               if (info.write)
                  write_shadow(info);
               else
                  check_val("rdata", rdata, ref_read(info));
               if (chk_lat)
                  check_val("latency", cyc - start_cyc[k], exp_latency(info));
               if (want_next >= 0)
                  check_val("done owner", k, want_next);
               want_next = req[1-k] ? 1 - k : -1;   // Waiting one goes next
               done_cnt[k]++;
            end
      end
   end

   //------------------------------------------------------------------------
   // Test sequence
   //------------------------------------------------------------------------
   initial
   begin
      smc_addr_t   a;
      logic [31:0] v, w;
      sys_clk3     = 1'b0;
      n_sys_reset3 = 1'b0;
      req          = 2'b00;
      req_info[0]  = '0;
      req_info[1]  = '0;
      lfsr         = 32'h1938;
      cyc          = 0;
      done_cnt     = '{0, 0};
      start_cyc    = '{0, 0};
      want_next    = -1;
      chk_lat      = 1'b1;
      checks       = 0;
      errors       = 0;
      tests        = 0;
      test_err0    = 0;
      for (int i = 0; i < 2048; i++)
         shadow[i] = fill_byte(i);
      repeat (8) @(posedge sys_clk3);
      #1 n_sys_reset3 = 1'b1;

      repeat (10)
      begin
         @(negedge sys_clk3);
         check_val("ext.n_cs", ext.n_cs, 2'b11);
         check_val("ext.n_be", ext.n_be, 4'hF);
         check_val("ext.n_we", ext.n_we, 1'b1);
         check_val("done", done, 2'b00);
      end
      end_test("idle bus after reset");
      @(posedge sys_clk3);
      #1;

      // Mixed sizes on the 32-bit bank
      get_bits(10, v);
      a = {22'd0, v[9:2], 2'b00};
      get_bits(32, w);
      xfer(0, a, size_32, 1'b1, w);
      get_bits(32, w);
      xfer(0, a + 2, size_16, 1'b1, w);
      get_bits(32, w);
      xfer(0, a + 1, size_8, 1'b1, w);
      xfer(0, a, size_32, 1'b0, '0);
      xfer(0, a, size_16, 1'b0, '0);
      xfer(0, a + 2, size_16, 1'b0, '0);
      for (int i = 0; i < 4; i++)
         xfer(0, a + i, size_8, 1'b0, '0);
      end_test("word, halfword and byte on the 32-bit bank");

      get_bits(10, v);
      a = 32'h1000_0000 | {22'd0, v[9:2], 2'b00};   // Bank 1
      get_bits(32, w);
      xfer(1, a, size_32, 1'b1, w);
      xfer(1, a, size_32, 1'b0, '0);
      end_test("word on the 8-bit bank");

      get_bits(32, w);
      xfer(0, a, size_16, 1'b1, w);
      get_bits(32, w);
      xfer(0, a + 2, size_16, 1'b1, w);
      xfer(0, a, size_16, 1'b0, '0);
      xfer(0, a + 2, size_16, 1'b0, '0);
      xfer(0, a, size_32, 1'b0, '0);
      end_test("halfwords on the 8-bit bank");

      // Both requesters at once, latency depends on waiting
      chk_lat = 1'b0;
      fork
         random_driver(0, 24);
         random_driver(1, 24);
      join
      want_next = -1;
      chk_lat   = 1'b1;
      end_test("two requesters, random transfers");

      for (int b = 0; b < 2; b++)
         for (int s = 0; s < 3; s++)
         begin
            get_bits(10, v);
            a = {3'd0, 1'(b), 18'd0, v[9:0]};
            xfer(b, a, smc_size_t'(s), 1'b0, '0);
            get_bits(32, w);
            xfer(1 - b, a, smc_size_t'(s), 1'b1, w);
         end
      end_test("latency per size and bank");

      $display("Summary: %0d tests, %0d checks, %0d errors", tests, checks, errors);
      if (errors == 0)
         $display("Regression passed");
      else
         $display("Regression failed");
      $finish;
   end

endmodule

`default_nettype wire

/* files.f */
verilog/smc_pkg.sv
verilog/smc_arbiter.sv
verilog/smc_state_ctrl.sv
verilog/smc_addr.sv
verilog/smc_data_path.sv
verilog/smc_top.sv
verif/smc_ext_mem.sv
verif/smc_tb.sv
